// File: rtl/fetch_consts.svh
`ifndef FETCH_CONSTS_SVH
`define FETCH_CONSTS_SVH

// program counter and instruction word widths
`define PC_WIDTH 16
`define INST_WIDTH 16

// slots fetched per cycle
`define FETCH_WIDTH 4

// instruction memory, word addressed
`define IMEM_ADDR_BITS 8
`define IMEM_DEPTH (1 << `IMEM_ADDR_BITS)

// branch history table, indexed by low pc bits
`define BHT_INDEX_BITS 6
`define BHT_DEPTH (1 << `BHT_INDEX_BITS)

`endif

// File: rtl/isa_pkg.sv
`default_nettype none

package isa_pkg;

    // major opcode in the top nibble
    typedef enum logic [3:0] {
        op_alu      = 4'h0,
        op_branch   = 4'hC,
        op_jump_imm = 4'hD,
        op_jump_reg = 4'hE
    } opcode_e;

    // field positions inside a 16-bit word
    localparam int OPC_MSB    = 15;
    localparam int OPC_LSB    = 12;
    localparam int BR_OFF_MSB = 7;
    localparam int BR_OFF_W   = 8;
    localparam int JIMM_MSB   = 11;
    localparam int JIMM_W     = 12;

    // unlisted opcodes fold into op_alu
    function automatic opcode_e decode_op(input logic [15:0] word);
        case (word[OPC_MSB:OPC_LSB])
            4'hC:    return op_branch;
            4'hD:    return op_jump_imm;
            4'hE:    return op_jump_reg;
            default: return op_alu;
        endcase
    endfunction

endpackage

`default_nettype wire

// File: rtl/fetch_pkg.sv
`default_nettype none

package fetch_pkg;

    // next pc source, highest priority first
    typedef enum logic [2:0] {
        src_recovery,
        src_hold,
        src_jump_reg,
        src_jump_imm,
        src_branch,
        src_seq
    } pc_src_e;

    // two-bit saturating counter, msb set means predict taken
    typedef enum logic [1:0] {
        strong_nt = 2'b00,
        weak_nt   = 2'b01,
        weak_t    = 2'b10,
        strong_t  = 2'b11
    } ctr_state_e;

    // register jump wait
    typedef enum logic {j_idle, j_wait_base} jwait_state_e;

endpackage

`default_nettype wire

// File: rtl/instr_mem.sv
`default_nettype none
`timescale 1ns/1ps
`include "fetch_consts.svh"

module instr_mem (
    input  wire logic                        clk,
    input  wire logic                        rst_n,
    // wishbone classic slave
    input  wire logic                        wb_cyc,
    input  wire logic                        wb_stb,
    input  wire logic                        wb_we,
    input  wire logic [`IMEM_ADDR_BITS-1:0]  wb_adr,
    input  wire logic [`INST_WIDTH-1:0]      wb_dat_w,
    output logic      [`INST_WIDTH-1:0]      wb_dat_r,
    output logic                             wb_ack,
    // fetch side
    input  wire logic [`PC_WIDTH-1:0]        fetch_pc,
    output logic      [`INST_WIDTH-1:0]      inst0,
    output logic      [`INST_WIDTH-1:0]      inst1,
    output logic      [`INST_WIDTH-1:0]      inst2,
    output logic      [`INST_WIDTH-1:0]      inst3
);

    localparam int AW = `IMEM_ADDR_BITS;
    localparam int FW = `FETCH_WIDTH;

    logic [`INST_WIDTH-1:0] mem [`IMEM_DEPTH];
    logic [AW-1:0]          rd_adr [FW];
    logic                   wb_req;

    ////////////////////////////////////////////////////////////
    // wishbone port
    ////////////////////////////////////////////////////////////

    // new request, not yet acked
    assign wb_req = wb_cyc && wb_stb && !wb_ack;

    // single-cycle ack pulse
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wb_ack <= 1'b0;
        end else begin
            wb_ack <= wb_req;
        end
    end

    // write lands on the ack edge, read data comes back with ack
    always_ff @(posedge clk) begin
        if (wb_req) begin
            if (wb_we) begin
                mem[wb_adr] <= wb_dat_w;
            end
            wb_dat_r <= mem[wb_adr];
        end
    end

    ////////////////////////////////////////////////////////////
    // fetch reads
    ////////////////////////////////////////////////////////////

    // four consecutive words, wrapping inside the array
    always_comb begin
        for (int i = 0; i < FW; i++) begin
            rd_adr[i] = fetch_pc[AW-1:0] + AW'(i);
        end
    end

    assign inst0 = mem[rd_adr[0]];
    assign inst1 = mem[rd_adr[1]];
    assign inst2 = mem[rd_adr[2]];
    assign inst3 = mem[rd_adr[3]];

endmodule

`default_nettype wire

// File: rtl/branch_scan.sv
`default_nettype none
`timescale 1ns/1ps
`include "fetch_consts.svh"

module branch_scan (
    input  wire logic [`PC_WIDTH-1:0]    pc,
    input  wire logic [`INST_WIDTH-1:0]  inst0,
    input  wire logic [`INST_WIDTH-1:0]  inst1,
    input  wire logic [`INST_WIDTH-1:0]  inst2,
    input  wire logic [`INST_WIDTH-1:0]  inst3,
    input  wire logic [`FETCH_WIDTH-1:0] pred_taken,
    output fetch_pkg::pc_src_e           ctrl_src,
    output logic      [`PC_WIDTH-1:0]    ctrl_target,
    output logic                         jump_reg_seen,
    output logic      [`FETCH_WIDTH-1:0] slot_valid,
    output logic      [`FETCH_WIDTH-1:0] pred_result,
    output logic      [`PC_WIDTH-1:0]    recv_pc
);

    import isa_pkg::*;
    import fetch_pkg::*;

    localparam int PW = `PC_WIDTH;
    localparam int FW = `FETCH_WIDTH;

    logic [`INST_WIDTH-1:0] inst_w   [FW];
    logic [PW-1:0]          slot_pc  [FW];
    logic [PW-1:0]          br_tgt   [FW];
    logic [PW-1:0]          jimm_tgt [FW];
    opcode_e                op       [FW];
    logic                   done;
    logic                   br_seen;

    assign inst_w = '{inst0, inst1, inst2, inst3};

    ////////////////////////////////////////////////////////////
    // per-slot decode and targets
    ////////////////////////////////////////////////////////////
    always_comb begin
        for (int i = 0; i < FW; i++) begin
            slot_pc[i]  = pc + PW'(i);
            op[i]       = decode_op(inst_w[i]);
            // pc relative, sign extended offset
            br_tgt[i]   = slot_pc[i] + {{(PW-BR_OFF_W){inst_w[i][BR_OFF_MSB]}},
                                        inst_w[i][BR_OFF_MSB:0]};
            // page of the slot plus 12-bit immediate
            jimm_tgt[i] = {slot_pc[i][PW-1:JIMM_W], inst_w[i][JIMM_MSB:0]};
        end
    end

    ////////////////////////////////////////////////////////////
    // group scan
    ////////////////////////////////////////////////////////////
    always_comb begin
        done          = 1'b0;
        br_seen       = 1'b0;
        slot_valid    = '0;
        pred_result   = '0;
        recv_pc       = '0;
        ctrl_src      = src_seq;
        ctrl_target   = '0;
        jump_reg_seen = 1'b0;
        for (int i = 0; i < FW; i++) begin
            if (!done) begin
                slot_valid[i] = 1'b1;
                // first branch sets the alternate path
                if (op[i] == op_branch && !br_seen) begin
                    br_seen = 1'b1;
                    recv_pc = pred_taken[i] ? slot_pc[i] + PW'(1) : br_tgt[i];
                end
                case (op[i])
                    op_branch: begin
                        // not-taken branch keeps the group going
                        if (pred_taken[i]) begin
                            pred_result[i] = 1'b1;
                            ctrl_src       = src_branch;
                            ctrl_target    = br_tgt[i];
                            done           = 1'b1;
                        end
                    end
                    op_jump_imm: begin
                        ctrl_src    = src_jump_imm;
                        ctrl_target = jimm_tgt[i];
                        done        = 1'b1;
                    end
                    op_jump_reg: begin
                        // target comes later from the register file
                        ctrl_src      = src_jump_reg;
                        jump_reg_seen = 1'b1;
                        done          = 1'b1;
                    end
                    default: ;
                endcase
            end
        end
    end

endmodule

`default_nettype wire

// File: rtl/branch_predictor.sv
`default_nettype none
`timescale 1ns/1ps
`include "fetch_consts.svh"

module branch_predictor (
    input  wire logic                        clk,
    input  wire logic                        rst_n,
    input  wire logic [`PC_WIDTH-1:0]        pc,
    output logic      [`FETCH_WIDTH-1:0]     pred_taken,
    // commit update
    input  wire logic                        update_en,
    input  wire logic [`PC_WIDTH-1:0]        update_pc,
    input  wire logic                        update_taken
);

    import fetch_pkg::*;

    localparam int PW = `PC_WIDTH;
    localparam int FW = `FETCH_WIDTH;
    localparam int BI = `BHT_INDEX_BITS;

    ctr_state_e bht [`BHT_DEPTH];
    logic [BI-1:0] lk_idx [FW];
    logic [BI-1:0] upd_idx;
    ctr_state_e    next_ctr;

    ////////////////////////////////////////////////////////////
    // lookup for all four slots
    ////////////////////////////////////////////////////////////
    always_comb begin
        for (int i = 0; i < FW; i++) begin
            lk_idx[i]     = BI'(pc + PW'(i));
            pred_taken[i] = bht[lk_idx[i]] inside {weak_t, strong_t};
        end
    end

    ////////////////////////////////////////////////////////////
    // commit update
    ////////////////////////////////////////////////////////////
    assign upd_idx = update_pc[BI-1:0];

    // saturate at both ends
    always_comb begin
        case (bht[upd_idx])
            strong_nt: next_ctr = update_taken ? weak_nt  : strong_nt;
            weak_nt:   next_ctr = update_taken ? weak_t   : strong_nt;
            weak_t:    next_ctr = update_taken ? strong_t : weak_nt;
            default:   next_ctr = update_taken ? strong_t : weak_t;
        endcase
    end

    // counters start weakly not-taken
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < `BHT_DEPTH; i++) begin
                bht[i] <= weak_nt;
            end
        end else if (update_en) begin
            bht[upd_idx] <= next_ctr;
        end
    end

endmodule

`default_nettype wire

// File: rtl/jump_resolver.sv
`default_nettype none
`timescale 1ns/1ps

module jump_resolver (
    input  wire logic clk,
    input  wire logic rst_n,
    input  wire logic jump_reg_seen,
    input  wire logic stall,
    input  wire logic mispredict,
    input  wire logic jump_base_rdy,
    output logic      waiting
);

    import fetch_pkg::*;

    jwait_state_e state;
    jwait_state_e state_nx;
    // low until the first edge out of reset
    logic         run_q;
    logic         accepted;

    // group taken by decode this cycle
    assign accepted = run_q && !stall && (state == j_idle);

    ////////////////////////////////////////////////////////////
    // wait FSM
    ////////////////////////////////////////////////////////////
    always_comb begin
        state_nx = state;
        case (state)
            j_idle: begin
                // redirect kills the jump group
                if (accepted && jump_reg_seen && !mispredict) begin
                    state_nx = j_wait_base;
                end
            end
            default: begin
                if (mispredict || jump_base_rdy) begin
                    state_nx = j_idle;
                end
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= j_idle;
            run_q <= 1'b0;
        end else begin
            state <= state_nx;
            run_q <= 1'b1;
        end
    end

    // no valid group in reset or while the base is pending
    assign waiting = !run_q || (state == j_wait_base);

endmodule

`default_nettype wire

// File: rtl/next_pc_sel.sv
`default_nettype none
`timescale 1ns/1ps
`include "fetch_consts.svh"

module next_pc_sel (
    input  wire logic                  clk,
    input  wire logic                  rst_n,
    input  wire logic                  mispredict,
    input  wire logic [`PC_WIDTH-1:0]  pc_recovery,
    input  wire logic                  stall,
    input  wire logic                  waiting,
    input  wire logic                  jump_base_rdy,
    input  wire logic [`PC_WIDTH-1:0]  jump_base,
    input  wire fetch_pkg::pc_src_e    ctrl_src,
    input  wire logic [`PC_WIDTH-1:0]  ctrl_target,
    output logic      [`PC_WIDTH-1:0]  pc
);

    import fetch_pkg::*;

    localparam int PW = `PC_WIDTH;

    pc_src_e       sel;
    logic [PW-1:0] pc_nx;

    ////////////////////////////////////////////////////////////
    // source priority
    ////////////////////////////////////////////////////////////
    always_comb begin
        if (mispredict) begin
            sel = src_recovery;
        end else if (waiting ? !jump_base_rdy : stall) begin
            // base strobe is one cycle, so waiting ignores stall
            sel = src_hold;
        end else if (waiting) begin
            sel = src_jump_reg;
        end else begin
            sel = ctrl_src;
        end
    end

    always_comb begin
        case (sel)
            src_recovery: pc_nx = pc_recovery;
            src_hold:     pc_nx = pc;
            // park on the jump group until the base shows up
            src_jump_reg: pc_nx = waiting ? jump_base : pc;
            src_jump_imm: pc_nx = ctrl_target;
            src_branch:   pc_nx = ctrl_target;
            default:      pc_nx = pc + PW'(`FETCH_WIDTH);
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc <= '0;
        end else begin
            pc <= pc_nx;
        end
    end

endmodule

`default_nettype wire

// File: rtl/fetch_unit.sv
`default_nettype none
`timescale 1ns/1ps
`include "fetch_consts.svh"

module fetch_unit (
    input  wire logic                                  clk,
    input  wire logic                                  rst_n,
    // wishbone program port
    input  wire logic                                  wb_cyc,
    input  wire logic                                  wb_stb,
    input  wire logic                                  wb_we,
    input  wire logic [`IMEM_ADDR_BITS-1:0]            wb_adr,
    input  wire logic [`INST_WIDTH-1:0]                wb_dat_w,
    output logic      [`INST_WIDTH-1:0]                wb_dat_r,
    output logic                                       wb_ack,
    // decode
    input  wire logic                                  stall,
    output logic                                       fetch_valid,
    output logic      [`PC_WIDTH-1:0]                  pc_to_dec,
    output logic      [`FETCH_WIDTH*`INST_WIDTH-1:0]   inst_to_dec,
    output logic      [`FETCH_WIDTH-1:0]               slot_valid,
    output logic      [`FETCH_WIDTH-1:0]               pred_result_to_dec,
    output logic      [`PC_WIDTH-1:0]                  recv_pc_to_dec,
    // commit
    input  wire logic                                  update_en,
    input  wire logic [`PC_WIDTH-1:0]                  update_pc,
    input  wire logic                                  update_taken,
    input  wire logic                                  mispredict,
    input  wire logic [`PC_WIDTH-1:0]                  pc_recovery,
    // register file
    input  wire logic                                  jump_base_rdy,
    input  wire logic [`PC_WIDTH-1:0]                  jump_base
);

    import fetch_pkg::*;

    logic [`PC_WIDTH-1:0]    pc;
    logic [`INST_WIDTH-1:0]  inst0, inst1, inst2, inst3;
    logic [`FETCH_WIDTH-1:0] pred_taken;
    pc_src_e                 ctrl_src;
    logic [`PC_WIDTH-1:0]    ctrl_target;
    logic                    jump_reg_seen;
    logic                    waiting;

    instr_mem imem (
        .clk, .rst_n, .wb_cyc, .wb_stb, .wb_we, .wb_adr, .wb_dat_w, .wb_dat_r, .wb_ack,
        .fetch_pc(pc), .inst0, .inst1, .inst2, .inst3
    );

    branch_predictor bpred (
        .clk, .rst_n, .pc, .pred_taken, .update_en, .update_pc, .update_taken
    );

    branch_scan scan (
        .pc, .inst0, .inst1, .inst2, .inst3, .pred_taken, .ctrl_src, .ctrl_target,
        .jump_reg_seen, .slot_valid, .pred_result(pred_result_to_dec),
        .recv_pc(recv_pc_to_dec)
    );

    jump_resolver jres (
        .clk, .rst_n, .jump_reg_seen, .stall, .mispredict, .jump_base_rdy, .waiting
    );

    next_pc_sel pcsel (
        .clk, .rst_n, .mispredict, .pc_recovery, .stall, .waiting, .jump_base_rdy,
        .jump_base, .ctrl_src, .ctrl_target, .pc
    );

    // slot 0 in the low word
    assign inst_to_dec = {inst3, inst2, inst1, inst0};
    assign pc_to_dec   = pc;
    assign fetch_valid = !waiting;

endmodule

`default_nettype wire

// File: test/fetch_checker.sv
`default_nettype none
`timescale 1ns/1ps
`include "fetch_consts.svh"

module fetch_checker (
    input  wire logic                    clk,
    // expected side, driven by the stimulus loop
    input  wire logic                    check_en,
    input  wire logic                    test_end,
    input  wire logic                    report,
    input  wire logic [7:0]              test_id,
    input  wire logic [`PC_WIDTH-1:0]    exp_pc,
    input  wire logic                    exp_valid,
    input  wire logic [`FETCH_WIDTH-1:0] exp_slots,
    input  wire logic [`FETCH_WIDTH-1:0] exp_pred,
    input  wire logic [`PC_WIDTH-1:0]    exp_recv,
    input  wire logic [`FETCH_WIDTH*`INST_WIDTH-1:0] exp_inst,
    input  wire logic                    rd_check,
    input  wire logic [`INST_WIDTH-1:0]  exp_rd,
    // observed DUT outputs
    input  wire logic                    fetch_valid,
    input  wire logic [`PC_WIDTH-1:0]    pc_to_dec,
    input  wire logic [`FETCH_WIDTH*`INST_WIDTH-1:0] inst_to_dec,
    input  wire logic [`FETCH_WIDTH-1:0] slot_valid,
    input  wire logic [`FETCH_WIDTH-1:0] pred_result_to_dec,
    input  wire logic [`PC_WIDTH-1:0]    recv_pc_to_dec,
    input  wire logic [`INST_WIDTH-1:0]  wb_dat_r,
    output int                           mismatches,
    output int                           checks
);

    int n_err = 0;
    int n_chk = 0;
    int test_errs = 0;
    int test_chks = 0;
    int tests_run = 0;
    int tests_failed = 0;

    assign mismatches = n_err;
    assign checks     = n_chk;

    // one compare, widened to 16 bits
    task automatic compare(input string name, input logic [15:0] exp, input logic [15:0] act);
        n_chk++;
        test_chks++;
        if (act !== exp) begin
            n_err++;
            test_errs++;
            $display("MISMATCH test %0d %s: expected 0x%h, got 0x%h", test_id, name, exp, act);
        end
    endtask

    ////////////////////////////////////////////////////////////
    // sample mid-cycle, inputs settle 1 ns after the edge
    ////////////////////////////////////////////////////////////
    always @(negedge clk) begin
        if (check_en) begin
            compare("pc_to_dec", exp_pc, pc_to_dec);
            compare("fetch_valid", 16'(exp_valid), 16'(fetch_valid));
            compare("slot_valid", 16'(exp_slots), 16'(slot_valid));
            compare("pred_result_to_dec", 16'(exp_pred), 16'(pred_result_to_dec));
            compare("recv_pc_to_dec", exp_recv, recv_pc_to_dec);
            // each slot word of the group
            for (int s = 0; s < `FETCH_WIDTH; s++) begin
                compare($sformatf("inst_to_dec[%0d]", s),
                        exp_inst[s*`INST_WIDTH +: `INST_WIDTH],
                        inst_to_dec[s*`INST_WIDTH +: `INST_WIDTH]);
            end
        end
        // wishbone readback data, valid with ack
        if (rd_check) begin
            compare("wb_dat_r", exp_rd, wb_dat_r);
        end
        if (test_end) begin
            tests_run++;
            if (test_errs == 0) begin
                $display("test %0d: ok (%0d checks)", test_id, test_chks);
            end else begin
                tests_failed++;
                $display("test %0d: %0d mismatches in %0d checks", test_id, test_errs, test_chks);
            end
            test_errs = 0;
            test_chks = 0;
        end
        if (report) begin
            $display("summary: %0d tests, %0d failed, %0d compares, %0d mismatches",
                     tests_run, tests_failed, n_chk, n_err);
        end
    end

endmodule

`default_nettype wire

// File: test/fetch_unit_tb.sv
`default_nettype none
`timescale 1ns/1ps
`include "fetch_consts.svh"

module fetch_unit_tb;

    import isa_pkg::*;

    localparam int PW = `PC_WIDTH;
    localparam int FW = `FETCH_WIDTH;
    localparam int ACK_TIMEOUT = 16;

    // side input applied in a step
    typedef enum logic [1:0] {act_none, act_train, act_redirect, act_base} act_e;

    typedef struct packed {
        logic [7:0]    test;
        logic          pre_stall;
        logic          stall;
        act_e          act;
        logic [PW-1:0] addr;
        logic [PW-1:0] exp_pc;
        logic          exp_valid;
        logic [FW-1:0] exp_slots;
    } step_t;

    logic                        clk = 1'b0;
    logic                        rst_n;
    logic                        wb_cyc, wb_stb, wb_we, wb_ack;
    logic [`IMEM_ADDR_BITS-1:0]  wb_adr;
    logic [`INST_WIDTH-1:0]      wb_dat_w, wb_dat_r;
    logic                        stall, fetch_valid;
    logic [PW-1:0]               pc_to_dec, recv_pc_to_dec;
    logic [FW*`INST_WIDTH-1:0]   inst_to_dec;
    logic [FW-1:0]               slot_valid, pred_result_to_dec;
    logic                        update_en, update_taken, mispredict, jump_base_rdy;
    logic [PW-1:0]               update_pc, pc_recovery, jump_base;
    // checker side
    logic                        check_en, test_end, report, rd_check, exp_valid;
    logic [7:0]                  test_id;
    logic [PW-1:0]               exp_pc, exp_recv;
    logic [FW-1:0]               exp_slots, exp_pred;
    logic [FW*`INST_WIDTH-1:0]   exp_inst;
    logic [`INST_WIDTH-1:0]      exp_rd;
    int                          mismatches, checks;

    step_t       steps [$];
    int          ref_ctr [`BHT_DEPTH];
    logic [31:0] lcg_state = 32'd21;

    fetch_unit dut (.*);
    fetch_checker chk (.*);

    always #5 clk = ~clk;

    function automatic int lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return int'(lcg_state[30:16]);
    endfunction

    // program image, filler carries the full address
    function automatic logic [15:0] image_word(input int a);
        case (a)
            13:      return 16'hC010;
            35:      return 16'hD040;
            69:      return 16'hE000;
            default: return {8'h12, a[7:0]};
        endcase
    endfunction

    // four image words from pc, slot 0 low
    function automatic logic [FW*`INST_WIDTH-1:0] group_words(input logic [PW-1:0] pc);
        logic [FW*`INST_WIDTH-1:0] g;
        logic [PW-1:0]             a;
        g = '0;
        for (int k = 0; k < FW; k++) begin
            a = pc + PW'(k);
            g[k*`INST_WIDTH +: `INST_WIDTH] = image_word(int'(a[`IMEM_ADDR_BITS-1:0]));
        end
        return g;
    endfunction

    ////////////////////////////////////////////////////////////
    // reference counter model
    ////////////////////////////////////////////////////////////
    task automatic predict_group(input logic [PW-1:0] pc, output logic [FW-1:0] pred,
                                 output logic [PW-1:0] recv);
        logic [PW-1:0] spc;
        logic [15:0]   w;
        logic          taken, ended, br_seen;
        int            i;
        pred = '0;
        recv = '0;
        ended = 1'b0;
        br_seen = 1'b0;
        for (i = 0; i < FW; i++) begin
            spc = pc + PW'(i);
            w = image_word(int'(spc[`IMEM_ADDR_BITS-1:0]));
            taken = ref_ctr[spc[`BHT_INDEX_BITS-1:0]] >= 2;
            if (!ended && w[15:12] == op_branch) begin
                // first branch gives the other path
                if (!br_seen) begin
                    recv = taken ? spc + 16'd1 : spc + {{8{w[7]}}, w[7:0]};
                end
                br_seen = 1'b1;
                pred[i] = taken;
                ended = taken;
            end else if (!ended && (w[15:12] == op_jump_imm || w[15:12] == op_jump_reg)) begin
                ended = 1'b1;
            end
        end
    endtask

    // saturating count up on a taken commit
    task automatic train(input logic [PW-1:0] a);
        if (ref_ctr[a[`BHT_INDEX_BITS-1:0]] < 3) begin
            ref_ctr[a[`BHT_INDEX_BITS-1:0]]++;
        end
    endtask

    task automatic idle_inputs(input logic hold);
        stall = hold;
        update_en = 1'b0;
        update_pc = '0;
        update_taken = 1'b0;
        mispredict = 1'b0;
        pc_recovery = '0;
        jump_base_rdy = 1'b0;
        jump_base = '0;
        check_en = 1'b0;
        test_end = 1'b0;
        rd_check = 1'b0;
        report = 1'b0;
    endtask

    task automatic end_run(input logic ok);
        if (ok && mismatches == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    endtask

    ////////////////////////////////////////////////////////////
    // wishbone master
    ////////////////////////////////////////////////////////////
    task automatic wait_ack();
        int n;
        n = 0;
        while (!wb_ack && n <= ACK_TIMEOUT) begin
            @(posedge clk);
            #1;
            n++;
        end
        if (!wb_ack) begin
            $display("timeout: no Wishbone ack after %0d cycles", n);
            end_run(1'b0);
        end
    endtask

    // fetch held by stall for the whole transfer
    task automatic wb_access(input logic we, input logic [7:0] adr, input logic [15:0] dat);
        @(posedge clk);
        #1;
        idle_inputs(1'b1);
        wb_cyc = 1'b1;
        wb_stb = 1'b1;
        wb_we = we;
        wb_adr = adr;
        wb_dat_w = dat;
        wait_ack();
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we = 1'b0;
    endtask

    ////////////////////////////////////////////////////////////
    // stimulus table
    ////////////////////////////////////////////////////////////
    task automatic add_step(input int test, input int pre, input int stl, input act_e act,
                            input int addr, input int pc, input int vld, input int slots);
        step_t s;
        s.test = 8'(test);
        s.pre_stall = pre[0];
        s.stall = stl[0];
        s.act = act;
        s.addr = PW'(addr);
        s.exp_pc = PW'(pc);
        s.exp_valid = vld[0];
        s.exp_slots = FW'(slots);
        steps.push_back(s);
    endtask

    task automatic build_table();
        // straight-line alu groups
        add_step(1, 0, 0, act_none, 0, 0, 1, 'hf);
        add_step(1, 0, 0, act_none, 0, 4, 1, 'hf);
        add_step(1, 0, 0, act_none, 0, 8, 1, 'hf);
        // cold branch at 13 falls through
        add_step(2, 0, 0, act_none, 0, 12, 1, 'hf);
        add_step(2, 0, 0, act_none, 0, 16, 1, 'hf);
        // train twice, then redirect back to the branch group
        add_step(3, 0, 1, act_train, 13, 20, 1, 'hf);
        add_step(3, 0, 1, act_train, 13, 20, 1, 'hf);
        add_step(3, 0, 0, act_redirect, 12, 20, 1, 'hf);
        add_step(3, 0, 0, act_none, 0, 12, 1, 'h3);
        add_step(3, 0, 0, act_none, 0, 29, 1, 'hf);
        // immediate jump in slot 2
        add_step(4, 0, 0, act_none, 0, 33, 1, 'h7);
        add_step(4, 0, 0, act_none, 0, 64, 1, 'hf);
        // register jump at 69, random stalls before and after accept
        add_step(5, 1, 0, act_none, 0, 68, 1, 'h3);
        add_step(5, 1, 0, act_none, 0, 68, 0, 'h3);
        add_step(5, 0, 0, act_base, 128, 68, 0, 'h3);
        add_step(5, 0, 0, act_none, 0, 128, 1, 'hf);
        // recovery beats stall
        add_step(6, 0, 1, act_redirect, 160, 132, 1, 'hf);
        add_step(6, 0, 1, act_none, 0, 160, 1, 'hf);
        add_step(6, 0, 0, act_none, 0, 160, 1, 'hf);
    endtask

    // one cycle of inputs plus its expected group
    task automatic drive(input step_t s, input logic stl, input act_e act, input logic last);
        logic [FW-1:0] pred;
        logic [PW-1:0] recv;
        @(posedge clk);
        #1;
        idle_inputs(stl);
        case (act)
            act_train: begin
                update_en = 1'b1;
                update_pc = s.addr;
                update_taken = 1'b1;
            end
            act_redirect: begin
                mispredict = 1'b1;
                pc_recovery = s.addr;
            end
            act_base: begin
                jump_base_rdy = 1'b1;
                jump_base = s.addr;
            end
            default: ;
        endcase
        predict_group(s.exp_pc, pred, recv);
        test_id = s.test;
        exp_pc = s.exp_pc;
        exp_valid = s.exp_valid;
        exp_slots = s.exp_slots;
        exp_pred = pred;
        exp_recv = recv;
        exp_inst = group_words(s.exp_pc);
        check_en = 1'b1;
        test_end = last;
        // counter moves at the edge after the strobe
        if (act == act_train) begin
            train(s.addr);
        end
    endtask

    task automatic apply_step(input step_t s, input logic last);
        int n;
        if (s.pre_stall) begin
            n = lcg_next() % 4 + 1;
            repeat (n) drive(s, 1'b1, act_none, 1'b0);
        end
        drive(s, s.stall, s.act, last);
    endtask

    initial begin
        int   i;
        logic last;
        rst_n = 1'b0;
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we = 1'b0;
        wb_adr = '0;
        wb_dat_w = '0;
        idle_inputs(1'b1);
        test_id = '0;
        exp_pc = '0;
        exp_valid = 1'b0;
        exp_slots = '0;
        exp_pred = '0;
        exp_recv = '0;
        exp_inst = '0;
        exp_rd = '0;
        // counters reset weakly not-taken
        for (i = 0; i < `BHT_DEPTH; i++) begin
            ref_ctr[i] = 1;
        end
        build_table();
        repeat (4) @(posedge clk);
        #1;
        rst_n = 1'b1;
        for (i = 0; i < `IMEM_DEPTH; i++) begin
            wb_access(1'b1, 8'(i), image_word(i));
        end
        for (i = 0; i < steps.size(); i++) begin
            // readback of the branch word opens test 2
            if (steps[i].test == 8'd2 && steps[i-1].test != 8'd2) begin
                wb_access(1'b0, 8'd13, 16'h0);
                test_id = steps[i].test;
                exp_rd = image_word(13);
                rd_check = 1'b1;
            end
            last = (i == steps.size() - 1) || (steps[i+1].test != steps[i].test);
            apply_step(steps[i], last);
        end
        @(posedge clk);
        #1;
        idle_inputs(1'b0);
        report = 1'b1;
        @(posedge clk);
        #1;
        end_run(checks > 0);
    end

endmodule

`default_nettype wire

// File: fetch_unit.f
+incdir+rtl
rtl/isa_pkg.sv
rtl/fetch_pkg.sv
rtl/instr_mem.sv
rtl/branch_scan.sv
rtl/branch_predictor.sv
rtl/jump_resolver.sv
rtl/next_pc_sel.sv
rtl/fetch_unit.sv
test/fetch_checker.sv
test/fetch_unit_tb.sv

// File: Makefile
# Verilator build and run for the fetch stage testbench

VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -j 0
TOP       ?= fetch_unit_tb
FILELIST  ?= fetch_unit.f
OBJ_DIR   ?= obj_dir
PASS_MSG  := All checks passed

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
